// ==== alu_rv32.f ====
alu_pkg.sv
alu_prep_if.sv
alu_lane_if.sv
alu_operand_prep.sv
alu_byte_lane.sv
alu_shifter.sv
alu_result_stage.sv
alu_top.sv
alu_asserts.sv
tb_alu.sv

// ==== run_alu_rv32.sh ====
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_alu -f alu_rv32.f --Mdir obj_dir -o sim_alu

status=0
./obj_dir/sim_alu > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== tb_alu.sv ====
// RV32 ALU testbench
`timescale 1ns/1ns

module tb_alu;

  localparam int clk_period     = 20;
  localparam int timeout_cycles = 10;
  localparam int random_count   = 400;
  localparam int num_ops        = int'(alu_pkg::ZEXTH) + 1;

  typedef struct packed {
    alu_pkg::alu_op_e op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      res;
    logic             br;
  } vector_t;

  logic             clk_i;
  logic             reset_i;
  logic             valid_i;
  alu_pkg::alu_op_e op_i;
  logic [31:0]      operand_a_i;
  logic [31:0]      operand_b_i;
  logic [31:0]      result_o;
  logic             branch_taken_o;
  logic             valid_o;
  vector_t          vectors [$];
  integer           seed;

  alu_top dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .result_o       (result_o),
    .branch_taken_o (branch_taken_o),
    .valid_o        (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(clk_period / 2);
      clk_i = ~clk_i;
    end
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [31:0] model_result(input alu_pkg::alu_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    int          s;
    int          n;
    r = '0;
    n = 0;
    s = int'(b[4:0]);
    case (op)
      alu_pkg::ADD:   r = a + b;
      alu_pkg::SUB:   r = a - b;
      alu_pkg::AND_L: r = a & b;
      alu_pkg::OR_L:  r = a | b;
      alu_pkg::XOR_L: r = a ^ b;
      alu_pkg::ANDN:  r = a & ~b;
      alu_pkg::ORN:   r = a | ~b;
      alu_pkg::XNOR:  r = ~(a ^ b);
      alu_pkg::SLL:   r = a << s;
      alu_pkg::SRL:   r = a >> s;
      alu_pkg::SRA:   r = $unsigned($signed(a) >>> s);
      // A shift by 32 clears the word, so amount 0 rotates cleanly
      alu_pkg::ROL:   r = (a << s) | (a >> (32 - s));
      alu_pkg::ROR:   r = (a >> s) | (a << (32 - s));
      alu_pkg::SLTS:  r = {31'b0, $signed(a) < $signed(b)};
      alu_pkg::SLTU:  r = {31'b0, a < b};
      alu_pkg::MIN:   r = ($signed(a) < $signed(b)) ? a : b;
      alu_pkg::MAX:   r = ($signed(a) < $signed(b)) ? b : a;
      alu_pkg::MINU:  r = (a < b) ? a : b;
      alu_pkg::MAXU:  r = (a < b) ? b : a;
      alu_pkg::CLZ, alu_pkg::CTZ, alu_pkg::CPOP: begin
        n = (op == alu_pkg::CPOP) ? 0 : 32;
        for (int i = 0; i < 32; i++) begin
          if (a[i] && op == alu_pkg::CPOP) n++;
          if (a[i] && op == alu_pkg::CLZ) n = 31 - i;
          if (a[31-i] && op == alu_pkg::CTZ) n = 31 - i;
        end
        r = 32'(n);
      end
      alu_pkg::ORCB: begin
        for (int k = 0; k < 4; k++) r[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hff : 8'h00;
      end
      alu_pkg::REV8:  r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      alu_pkg::BREV8: begin
        for (int k = 0; k < 4; k++) begin
          for (int j = 0; j < 8; j++) r[8*k+j] = a[8*k+7-j];
        end
      end
      alu_pkg::SEXTB: r = {{24{a[7]}}, a[7:0]};
      alu_pkg::SEXTH: r = {{16{a[15]}}, a[15:0]};
      alu_pkg::ZEXTH: r = {16'h0000, a[15:0]};
      // Branch compares leave the result at zero
      default:        r = '0;
    endcase
    return r;
  endfunction

  function automatic logic model_branch(input alu_pkg::alu_op_e op,
                                        input logic [31:0] a, input logic [31:0] b);
    case (op)
      alu_pkg::EQ:  return a == b;
      alu_pkg::NE:  return a != b;
      alu_pkg::LTS: return $signed(a) < $signed(b);
      alu_pkg::LTU: return a < b;
      alu_pkg::GES: return $signed(a) >= $signed(b);
      alu_pkg::GEU: return a >= b;
      default:      return 1'b1;
    endcase
  endfunction

  // --------------------
  // Checking
  // --------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Returns 1 ns after the edge that registered the operation
  task automatic wait_for_valid(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
    end while (!valid_o && cycles < timeout_cycles);
    if (!valid_o) begin
      abort_run($sformatf("Timeout in %s, valid_o never arrived", name));
    end
    compare_value({name, " latency"}, 32'd1, 32'(cycles));
  endtask

  // Entered 2 ns after a rising edge, valid_i stays high for back-to-back use
  task automatic apply_op(input string name, input alu_pkg::alu_op_e op,
                          input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] exp_res, input logic exp_br);
    op_i        = op;
    operand_a_i = a;
    operand_b_i = b;
    valid_i     = 1'b1;
    wait_for_valid(name);
    compare_value({name, " result"}, exp_res, result_o);
    compare_value({name, " branch"}, {31'b0, exp_br}, {31'b0, branch_taken_o});
    #1;
  endtask

  task automatic add_vector(input alu_pkg::alu_op_e op, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] res, input logic br);
    vectors.push_back(vector_t'{op, a, b, res, br});
  endtask

  // --------------------
  // Corner table
  // --------------------
  task automatic fill_vectors();
    add_vector(alu_pkg::ADD,   32'hffffffff, 32'h00000001, 32'h00000000, 1'b1);
    add_vector(alu_pkg::SUB,   32'h00000000, 32'h00000001, 32'hffffffff, 1'b1);
    add_vector(alu_pkg::ANDN,  32'hf0f0f0f0, 32'hff00ff00, 32'h00f000f0, 1'b1);
    add_vector(alu_pkg::XNOR,  32'h12345678, 32'h12345678, 32'hffffffff, 1'b1);
    add_vector(alu_pkg::SLL,   32'h00000001, 32'h00000021, 32'h00000002, 1'b1);
    add_vector(alu_pkg::SRA,   32'h80000000, 32'h00000004, 32'hf8000000, 1'b1);
    add_vector(alu_pkg::ROL,   32'h80000001, 32'h00000000, 32'h80000001, 1'b1);
    add_vector(alu_pkg::ROL,   32'h80000001, 32'h0000001f, 32'hc0000000, 1'b1);
    add_vector(alu_pkg::ROR,   32'h80000001, 32'h00000000, 32'h80000001, 1'b1);
    add_vector(alu_pkg::ROR,   32'h80000001, 32'h0000001f, 32'h00000003, 1'b1);
    add_vector(alu_pkg::SLTS,  32'hffffffff, 32'h00000001, 32'h00000001, 1'b1);
    add_vector(alu_pkg::SLTU,  32'hffffffff, 32'h00000001, 32'h00000000, 1'b1);
    add_vector(alu_pkg::EQ,    32'h00000005, 32'h00000005, 32'h00000000, 1'b1);
    add_vector(alu_pkg::NE,    32'h00000005, 32'h00000005, 32'h00000000, 1'b0);
    add_vector(alu_pkg::LTS,   32'hffffffff, 32'h00000000, 32'h00000000, 1'b1);
    add_vector(alu_pkg::LTU,   32'hffffffff, 32'h00000000, 32'h00000000, 1'b0);
    add_vector(alu_pkg::GES,   32'h80000000, 32'h7fffffff, 32'h00000000, 1'b0);
    add_vector(alu_pkg::GEU,   32'h80000000, 32'h7fffffff, 32'h00000000, 1'b1);
    add_vector(alu_pkg::MIN,   32'hffffffff, 32'h00000001, 32'hffffffff, 1'b1);
    add_vector(alu_pkg::MAXU,  32'hffffffff, 32'h00000001, 32'hffffffff, 1'b1);
    add_vector(alu_pkg::CLZ,   32'h00000000, 32'h00000000, 32'h00000020, 1'b1);
    add_vector(alu_pkg::CLZ,   32'hffffffff, 32'h00000000, 32'h00000000, 1'b1);
    add_vector(alu_pkg::CTZ,   32'h00000000, 32'h00000000, 32'h00000020, 1'b1);
    add_vector(alu_pkg::CTZ,   32'h00010000, 32'h00000000, 32'h00000010, 1'b1);
    add_vector(alu_pkg::CPOP,  32'hffffffff, 32'h00000000, 32'h00000020, 1'b1);
    add_vector(alu_pkg::ORCB,  32'h00800100, 32'h00000000, 32'h00ffff00, 1'b1);
    add_vector(alu_pkg::REV8,  32'h12345678, 32'h00000000, 32'h78563412, 1'b1);
    add_vector(alu_pkg::BREV8, 32'h01020380, 32'h00000000, 32'h8040c001, 1'b1);
    add_vector(alu_pkg::SEXTB, 32'h00000080, 32'h00000000, 32'hffffff80, 1'b1);
    add_vector(alu_pkg::SEXTH, 32'h00008000, 32'h00000000, 32'hffff8000, 1'b1);
    add_vector(alu_pkg::ZEXTH, 32'hffff8000, 32'h00000000, 32'h00008000, 1'b1);
  endtask

  initial begin
    alu_pkg::alu_op_e op;
    logic [31:0]      a;
    logic [31:0]      b;
    seed        = 32'he9665a19;
    reset_i     = 1'b1;
    valid_i     = 1'b0;
    op_i        = alu_pkg::ADD;
    operand_a_i = '0;
    operand_b_i = '0;
    fill_vectors();
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    compare_value("reset valid_o", 32'd0, {31'b0, valid_o});
    compare_value("reset result_o", 32'd0, result_o);
    compare_value("reset branch_taken_o", 32'd0, {31'b0, branch_taken_o});

    // Table rows go back to back
    foreach (vectors[i]) begin
      op = vectors[i].op;
      apply_op($sformatf("%s[%0d]", op.name(), i), op, vectors[i].a, vectors[i].b,
               vectors[i].res, vectors[i].br);
    end

    // One idle cycle with new inputs keeps the last result
    valid_i     = 1'b0;
    op_i        = alu_pkg::ADD;
    operand_a_i = 32'h00000001;
    operand_b_i = 32'h00000001;
    @(posedge clk_i);
    #1;
    compare_value("idle valid_o", 32'd0, {31'b0, valid_o});
    compare_value("idle result_o", vectors[vectors.size()-1].res, result_o);
    #1;

    for (int n = 0; n < random_count; n++) begin
      op = alu_pkg::alu_op_e'(6'($unsigned($random(seed)) % num_ops));
      a  = $random(seed);
      b  = $random(seed);
      // Equal operands now and then for EQ and NE
      if (b[1:0] == 2'b00) begin
        b = a;
      end
      apply_op($sformatf("random %s[%0d]", op.name(), n), op, a, b,
               model_result(op, a, b), model_branch(op, a, b));
    end
    valid_i = 1'b0;

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== alu_asserts.sv ====
// ALU output register assertions
`timescale 1ns/1ns

module alu_asserts (
  input logic             clk_i,
  input logic             reset_i,
  input logic             valid_i,
  input alu_pkg::alu_op_e op_i,
  input logic             out_branch_i,
  input logic             out_valid_i
);

  logic branch_op;

  assign branch_op = op_i inside {alu_pkg::EQ, alu_pkg::NE, alu_pkg::LTS,
                                  alu_pkg::LTU, alu_pkg::GES, alu_pkg::GEU};

  idle_after_reset: assert property (@(posedge clk_i) reset_i |=> !out_valid_i)
    else $error("valid_o high in the cycle after reset");

  valid_follows: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i |=> out_valid_i)
    else $error("valid_o missing one cycle after valid_i");

  idle_follows: assert property (@(posedge clk_i) disable iff (reset_i)
    !valid_i |=> !out_valid_i)
    else $error("valid_o high without valid_i");

  // Non-branch operations always report taken
  non_branch_taken: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_i && !branch_op) |=> out_branch_i)
    else $error("branch_taken_o low after a non-branch operation");

endmodule

bind alu_result_stage alu_asserts u_asserts (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .valid_i      (valid_i),
  .op_i         (prep.op),
  .out_branch_i (branch_taken_o),
  .out_valid_i  (valid_o)
);

// ==== alu_top.sv ====
// RV32 integer ALU top level
`timescale 1ns/1ns

module alu_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     valid_i,
  input  alu_pkg::alu_op_e         op_i,
  input  logic [alu_pkg::xlen-1:0] operand_a_i,
  input  logic [alu_pkg::xlen-1:0] operand_b_i,
  output logic [alu_pkg::xlen-1:0] result_o,
  output logic                     branch_taken_o,
  output logic                     valid_o
);

  logic [alu_pkg::xlen-1:0] shift_result;

  alu_prep_if prep_if ();
  alu_lane_if lane_if [alu_pkg::lane_count] ();

  // --------------------
  // Combinational datapath
  // --------------------
  alu_operand_prep u_prep (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .prep        (prep_if)
  );

  alu_shifter u_shifter (
    .prep           (prep_if),
    .shift_result_o (shift_result)
  );

  for (genvar i = 0; i < alu_pkg::lane_count; i++) begin : gen_lanes
    alu_byte_lane #(
      .lane_index (i)
    ) u_lane (
      .prep  (prep_if),
      .lanes (lane_if[i])
    );
  end

  // --------------------
  // Result and register
  // --------------------
  alu_result_stage u_result (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .valid_i        (valid_i),
    .prep           (prep_if),
    .lanes          (lane_if),
    .shift_result_i (shift_result),
    .result_o       (result_o),
    .branch_taken_o (branch_taken_o),
    .valid_o        (valid_o)
  );

endmodule

// ==== alu_result_stage.sv ====
// ALU result selection and output register
`timescale 1ns/1ns

module alu_result_stage (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     valid_i,
  alu_prep_if.result               prep,
  alu_lane_if.result               lanes [alu_pkg::lane_count],
  input  logic [alu_pkg::xlen-1:0] shift_result_i,
  output logic [alu_pkg::xlen-1:0] result_o,
  output logic                     branch_taken_o,
  output logic                     valid_o
);

  logic [3:0]                     pop_cnt [alu_pkg::lane_count];
  logic [3:0]                     lz_cnt  [alu_pkg::lane_count];
  alu_pkg::alu_word_u             orcb_w;
  alu_pkg::alu_word_u             brev_w;
  alu_pkg::alu_word_u             rev8_w;
  logic [alu_pkg::cnt_width-1:0]  cpop_total;
  logic [alu_pkg::cnt_width-1:0]  lz_total;
  logic                           lz_found;
  logic [alu_pkg::xlen-1:0]       a;
  logic [alu_pkg::xlen-1:0]       b;
  logic [alu_pkg::xlen-1:0]       result_d;
  logic                           branch_d;

  assign a = prep.operand_a.word;
  assign b = prep.operand_b.word;

  // --------------------
  // Lane combining
  // --------------------
  for (genvar g = 0; g < alu_pkg::lane_count; g++) begin : gen_unpack
    assign pop_cnt[g]      = lanes[g].pop_cnt;
    assign lz_cnt[g]       = lanes[g].lz_cnt;
    assign orcb_w.bytes[g] = lanes[g].orcb_byte;
    assign brev_w.bytes[g] = lanes[g].brev_byte;
    // Byte order reversed for REV8
    assign rev8_w.bytes[g] = prep.operand_a.bytes[alu_pkg::lane_count-1-g];
  end

  always_comb begin
    cpop_total = '0;
    for (int i = 0; i < alu_pkg::lane_count; i++) begin
      cpop_total = cpop_total + {{(alu_pkg::cnt_width-4){1'b0}}, pop_cnt[i]};
    end
  end

  // Add up empty upper lanes down to the first lane with a set bit
  // An all-zero source sums to 32
  always_comb begin
    lz_total = '0;
    lz_found = 1'b0;
    for (int i = alu_pkg::lane_count - 1; i >= 0; i--) begin
      if (!lz_found) begin
        lz_total = lz_total + {{(alu_pkg::cnt_width-4){1'b0}}, lz_cnt[i]};
        lz_found = (lz_cnt[i] != 4'd8);
      end
    end
  end

  // --------------------
  // Result mux
  // --------------------
  always_comb begin
    case (prep.op)
      alu_pkg::ADD, alu_pkg::SUB:     result_d = prep.adder_result;
      alu_pkg::AND_L, alu_pkg::ANDN:  result_d = a & prep.logic_b;
      alu_pkg::OR_L, alu_pkg::ORN:    result_d = a | prep.logic_b;
      alu_pkg::XOR_L, alu_pkg::XNOR:  result_d = a ^ prep.logic_b;
      alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA,
      alu_pkg::ROL, alu_pkg::ROR:     result_d = shift_result_i;
      alu_pkg::SLTS, alu_pkg::SLTU:   result_d = {{(alu_pkg::xlen-1){1'b0}}, prep.less};
      alu_pkg::MIN, alu_pkg::MINU:    result_d = prep.less ? a : b;
      alu_pkg::MAX, alu_pkg::MAXU:    result_d = prep.less ? b : a;
      alu_pkg::CLZ, alu_pkg::CTZ:
        result_d = {{(alu_pkg::xlen-alu_pkg::cnt_width){1'b0}}, lz_total};
      alu_pkg::CPOP:
        result_d = {{(alu_pkg::xlen-alu_pkg::cnt_width){1'b0}}, cpop_total};
      alu_pkg::ORCB:                  result_d = orcb_w.word;
      alu_pkg::REV8:                  result_d = rev8_w.word;
      alu_pkg::BREV8:                 result_d = brev_w.word;
      alu_pkg::SEXTB:  result_d = {{(alu_pkg::xlen-8){a[7]}}, a[7:0]};
      alu_pkg::SEXTH:  result_d = {{(alu_pkg::xlen-16){a[15]}}, a[15:0]};
      alu_pkg::ZEXTH:  result_d = {{(alu_pkg::xlen-16){1'b0}}, a[15:0]};
      default:                        result_d = '0;
    endcase
  end

  // Branch outcome, always taken for non-branch ops
  always_comb begin
    case (prep.op)
      alu_pkg::EQ:                  branch_d = prep.adder_zero;
      alu_pkg::NE:                  branch_d = ~prep.adder_zero;
      alu_pkg::LTS, alu_pkg::LTU:   branch_d = prep.less;
      alu_pkg::GES, alu_pkg::GEU:   branch_d = ~prep.less;
      default:                      branch_d = 1'b1;
    endcase
  end

  // --------------------
  // Output register
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o        <= 1'b0;
      result_o       <= '0;
      branch_taken_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      // Hold last result while idle
      if (valid_i) begin
        result_o       <= result_d;
        branch_taken_o <= branch_d;
      end
    end
  end

endmodule

// ==== alu_shifter.sv ====
// ALU shifter and rotator
`timescale 1ns/1ns

module alu_shifter (
  alu_prep_if.shift                prep,
  output logic [alu_pkg::xlen-1:0] shift_result_o
);

  logic                              shift_left;
  logic                              shift_arith;
  logic                              rotate;
  logic [alu_pkg::shamt_width-1:0]   amt;
  logic [alu_pkg::cnt_width-1:0]     comp_amt;
  logic [alu_pkg::xlen-1:0]          shift_in;
  logic [alu_pkg::xlen:0]            right_wide;
  logic [alu_pkg::xlen-1:0]          right_out;
  logic [alu_pkg::xlen-1:0]          left_out;

  assign shift_left  = prep.op inside {alu_pkg::SLL, alu_pkg::ROL};
  assign shift_arith = (prep.op == alu_pkg::SRA);
  assign rotate      = prep.op inside {alu_pkg::ROL, alu_pkg::ROR};

  assign amt = prep.operand_b.word[alu_pkg::shamt_width-1:0];

  // xlen minus amount, xlen is 2**shamt_width
  assign comp_amt = {1'b1, {alu_pkg::shamt_width{1'b0}}} - {1'b0, amt};

  // Left forms run through the right shifter on reversed A
  assign shift_in = shift_left ? prep.operand_a_rev.word : prep.operand_a.word;

  // --------------------
  // Right shifter
  // --------------------
  assign right_wide = $unsigned($signed({shift_arith & shift_in[alu_pkg::xlen-1], shift_in})
                                >>> amt);

  // Rotate adds back the bits shifted out, zero amount shifts them away fully
  always_comb begin
    right_out = right_wide[alu_pkg::xlen-1:0];
    if (rotate) begin
      right_out = right_out | (shift_in << comp_amt);
    end
  end

  // Undo the reversal for left forms
  always_comb begin
    for (int k = 0; k < alu_pkg::xlen; k++) begin
      left_out[k] = right_out[alu_pkg::xlen-1-k];
    end
  end

  assign shift_result_o = shift_left ? left_out : right_out;

endmodule

// ==== alu_byte_lane.sv ====
// ALU byte lane
`timescale 1ns/1ns

module alu_byte_lane #(
  parameter int lane_index = 0
) (
  alu_prep_if.lane  prep,
  alu_lane_if.lane  lanes
);

  logic [7:0] a_byte;
  logic [7:0] src_byte;
  logic [7:0] brev;
  logic [3:0] pop;
  logic [3:0] lz;

  assign a_byte   = prep.operand_a.bytes[lane_index];
  assign src_byte = prep.count_src.bytes[lane_index];

  always_comb begin
    for (int k = 0; k < 8; k++) begin
      brev[k] = a_byte[7-k];
    end
  end

  always_comb begin
    pop = '0;
    for (int k = 0; k < 8; k++) begin
      pop = pop + {3'b000, src_byte[k]};
    end
  end

  // Highest set bit wins, empty byte keeps 8
  always_comb begin
    lz = 4'd8;
    for (int k = 0; k < 8; k++) begin
      if (src_byte[k]) begin
        lz = 4'(7 - k);
      end
    end
  end

  assign lanes.orcb_byte = {8{|a_byte}};
  assign lanes.brev_byte = brev;
  assign lanes.pop_cnt   = pop;
  assign lanes.lz_cnt    = lz;

endmodule

// ==== alu_operand_prep.sv ====
// ALU operand preparation
// Reversal, shared adder and less-than compare
`timescale 1ns/1ns

module alu_operand_prep (
  input  logic [alu_pkg::xlen-1:0] operand_a_i,
  input  logic [alu_pkg::xlen-1:0] operand_b_i,
  input  alu_pkg::alu_op_e         op_i,
  alu_prep_if.prep                 prep
);

  alu_pkg::alu_word_u          a_u;
  alu_pkg::alu_word_u          a_rev;
  logic                        negate_b;
  logic [alu_pkg::xlen:0]      adder_in_a;
  logic [alu_pkg::xlen:0]      adder_in_b;
  logic [alu_pkg::xlen:0]      adder_sum;
  logic [alu_pkg::xlen-1:0]    adder_result;
  logic                        signed_cmp;

  assign a_u = operand_a_i;

  // Byte order swapped and bits swapped within each byte
  always_comb begin
    for (int b = 0; b < alu_pkg::lane_count; b++) begin
      for (int k = 0; k < 8; k++) begin
        a_rev.bytes[alu_pkg::lane_count-1-b][k] = a_u.bytes[b][7-k];
      end
    end
  end

  // --------------------
  // Adder
  // --------------------
  assign negate_b = op_i inside {alu_pkg::SUB, alu_pkg::EQ, alu_pkg::NE,
                                 alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR};

  // Extra low bit carries the +1 of the two's complement
  assign adder_in_a   = {operand_a_i, 1'b1};
  assign adder_in_b   = {operand_b_i, 1'b0} ^ {(alu_pkg::xlen+1){negate_b}};
  assign adder_sum    = adder_in_a + adder_in_b;
  assign adder_result = adder_sum[alu_pkg::xlen:1];

  // --------------------
  // Compare
  // --------------------
  assign signed_cmp = op_i inside {alu_pkg::SLTS, alu_pkg::LTS, alu_pkg::GES,
                                   alu_pkg::MIN, alu_pkg::MAX};

  // Sign extend only for signed forms
  assign prep.less =
    $signed({signed_cmp & operand_a_i[alu_pkg::xlen-1], operand_a_i}) <
    $signed({signed_cmp & operand_b_i[alu_pkg::xlen-1], operand_b_i});

  // --------------------
  // Outputs
  // --------------------
  assign prep.op            = op_i;
  assign prep.operand_a     = a_u;
  assign prep.operand_b     = operand_b_i;
  assign prep.operand_a_rev = a_rev;
  // CTZ becomes a leading-zero count of reversed A
  assign prep.count_src     = (op_i == alu_pkg::CTZ) ? a_rev : a_u;
  assign prep.adder_result  = adder_result;
  assign prep.adder_zero    = ~|adder_result;
  assign prep.logic_b       = adder_in_b[alu_pkg::xlen:1];

endmodule

// ==== alu_lane_if.sv ====
// Byte lane result bus
`timescale 1ns/1ns

interface alu_lane_if;

  // Byte is FF when any bit set
  logic [7:0] orcb_byte;
  // Bits of the byte in reverse order
  logic [7:0] brev_byte;
  // Set bits in the count source byte, 0 to 8
  logic [3:0] pop_cnt;
  // Leading zeros of the count source byte, 8 when empty
  logic [3:0] lz_cnt;

  modport lane (
    output orcb_byte, brev_byte, pop_cnt, lz_cnt
  );

  modport result (
    input orcb_byte, brev_byte, pop_cnt, lz_cnt
  );

endinterface

// ==== alu_prep_if.sv ====
// Prepared operand bus
`timescale 1ns/1ns

interface alu_prep_if;

  alu_pkg::alu_op_e          op;
  alu_pkg::alu_word_u        operand_a;
  alu_pkg::alu_word_u        operand_b;
  alu_pkg::alu_word_u        operand_a_rev;
  // A, or reversed A for CTZ
  alu_pkg::alu_word_u        count_src;
  logic [alu_pkg::xlen-1:0]  adder_result;
  logic                      adder_zero;
  logic                      less;
  // B, inverted for ANDN, ORN and XNOR
  logic [alu_pkg::xlen-1:0]  logic_b;

  modport prep (
    output op, operand_a, operand_b, operand_a_rev, count_src,
    output adder_result, adder_zero, less, logic_b
  );

  modport shift (input op, operand_a, operand_a_rev, operand_b);

  modport lane (input operand_a, count_src);

  modport result (
    input op, operand_a, operand_b, adder_result, adder_zero, less, logic_b
  );

endinterface

// ==== alu_pkg.sv ====
// RV32 ALU shared definitions
// Widths, operation codes and operand word type

package alu_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int xlen        = 32;
  localparam int lane_count  = xlen / 8;
  localparam int shamt_width = 5;
  // Holds a count of 0 to xlen
  localparam int cnt_width   = 6;

  // --------------------
  // Operations
  // --------------------
  typedef enum logic [5:0] {
    // Adder
    ADD,
    SUB,
    // Bitwise logic, plain and with inverted B
    AND_L,
    OR_L,
    XOR_L,
    ANDN,
    ORN,
    XNOR,
    // Shifts and rotates
    SLL,
    SRL,
    SRA,
    ROL,
    ROR,
    // Set less than
    SLTS,
    SLTU,
    // Branch compares
    EQ,
    NE,
    LTS,
    LTU,
    GES,
    GEU,
    // Min and max
    MIN,
    MAX,
    MINU,
    MAXU,
    // Bit counts
    CLZ,
    CTZ,
    CPOP,
    // Byte manipulation
    ORCB,
    REV8,
    BREV8,
    // Extension
    SEXTB,
    SEXTH,
    ZEXTH
  } alu_op_e;

  // --------------------
  // Operand word
  // --------------------
  // Same 32 bits seen as one word or as four bytes, byte 0 is the low byte
  typedef union packed {
    logic [xlen-1:0]                word;
    logic [lane_count-1:0][7:0]     bytes;
  } alu_word_u;

endpackage
